/* list.f */
hdl/ice51_pkg.sv
hdl/uart_rx_loader.sv
hdl/uart_tx.sv
hdl/ice51_decode.sv
hdl/ice51_pc.sv
hdl/ice51_datapath.sv
hdl/ice51_top.sv
test/ice51_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ice51_tb -f list.f -o ice51_sim &&
./obj_dir/ice51_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Errors found" sim.log && exit 1 || grep -q "No errors" sim.log || exit 1
echo "simulation passed"

/* test/ice51_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_tb import ice51_pkg::*; ();

   localparam int FRAME_CLKS = 10 * (BAUD_DIV + 1);
   localparam int N_TESTS    = 3;
   localparam int N_PRINTS   = 7 + 10 + 6;   // bytes printed by the three programs
   localparam int LIMIT_NS   = (N_TESTS * (LOAD_BYTES + 4) + N_PRINTS) * FRAME_CLKS * 8
                               + 100_000;

   localparam logic [7:0] ALU_OPS [0:6] = '{OP_MOV_I, OP_ADD_I, OP_ADDC_I, OP_SUBB_I,
                                            OP_ANL_I, OP_ORL_I, OP_XRL_I};
   localparam logic [7:0] ONE_OPS [0:9] = '{OP_SETB_C, OP_RLC, OP_RRC, OP_CLR_C, OP_RLC,
                                            OP_INC_A, OP_DEC_A, OP_CPL_A, OP_CLR_A, OP_RL};

   logic               i_clk = 1'b0;
   logic               i_nrst;
   logic               i_uart_rx;
   logic [7:0]         i_code_data;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   logic [7:0]         o_code_data;

   logic [7:0]         mem  [LOAD_BYTES];   // code memory model
   logic [7:0]         prog [LOAD_BYTES];   // image sent over the uart
   logic [CODE_AW-1:0] rd_addr;
   logic [31:0]        seed = 32'haf47_b66c;
   logic [7:0]         exp_q [$];
   logic [7:0]         rx_q [$];
   logic               model_c;             // carry the reference expects
   logic               loading = 1'b0;
   logic               line_err;
   int                 pos;
   int                 load_idx;
   int                 n_exp = 0;
   int                 n_cmp = 0;
   int                 errors = 0;

   ice51_top dut (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   always #4 i_clk = ~i_clk;

   ////////////////////////////////////////////////////////////////////////////
   // code memory, one clock of read latency

   always @(negedge i_clk) begin
      if (o_code_wr) mem[o_code_addr] = o_code_data;
      rd_addr = o_code_addr;
   end

   always @(posedge i_clk) begin
      #1 i_code_data = mem[rd_addr];
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [7:0] next_byte();
      seed = xorshift(seed);
      return seed[7:0];
   endfunction

   // 8051 result of MOV A,#a then op; returns {carry, a}
   function automatic logic [8:0] ref_alu(input logic [7:0] op, input logic [7:0] a,
                                          input logic [7:0] y, input logic c);
      int         t;
      logic [7:0] res;
      logic       cy;
      res = a;
      cy  = c;
      case (op)
         OP_MOV_I:  res = y;
         OP_ADD_I: begin
            t   = a + y;
            res = t[7:0];
            cy  = (t > 255);
         end
         OP_ADDC_I: begin
            t   = a + y + c;
            res = t[7:0];
            cy  = (t > 255);
         end
         OP_SUBB_I: begin
            t   = a - y - c;
            res = t[7:0];
            cy  = (t < 0);   // borrow
         end
         OP_ANL_I:  res = a & y;
         OP_ORL_I:  res = a | y;
         OP_XRL_I:  res = a ^ y;
         OP_INC_A: begin
            t   = a + 1;
            res = t[7:0];
            cy  = (t > 255);   // this core lets inc a set the carry
         end
         OP_DEC_A:  res = a - 8'd1;
         OP_CPL_A:  res = ~a;
         OP_CLR_A:  res = 8'h00;
         OP_RL:     res = {a[6:0], a[7]};
         OP_RLC: begin
            res = {a[6:0], c};
            cy  = a[7];
         end
         OP_RRC: begin
            res = {c, a[7:1]};
            cy  = a[0];
         end
         OP_CLR_C:  cy = 1'b0;
         OP_SETB_C: cy = 1'b1;
         default: ;
      endcase
      return {cy, res};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // program generator

   task automatic emit(input logic [7:0] b);
      prog[pos] = b;
      pos = pos + 1;
   endtask

   // save A in B, poll busy, restore A and send it
   task automatic emit_print();
      emit(OP_MOV_DIR_A);
      emit(ADDR_B);
      emit(OP_MOV_DPTR);
      emit(TX_STAT_ADDR[15:8]);
      emit(TX_STAT_ADDR[7:0]);
      emit(OP_MOVX_RD);
      emit(OP_JNZ);
      emit(8'hFD);          // back to the movx
      emit(OP_MOV_A_DIR);
      emit(ADDR_B);
      emit(OP_MOV_DPTR);
      emit(TX_DATA_ADDR[15:8]);
      emit(TX_DATA_ADDR[7:0]);
      emit(OP_MOVX_WR);
   endtask

   task automatic expect_byte(input logic [7:0] b);
      exp_q.push_back(b);
      n_exp++;
   endtask

   task automatic add_print_block(input logic [7:0] op);
      logic [7:0] x;
      logic [7:0] y;
      logic [8:0] r;
      x = next_byte();
      y = next_byte();
      emit(OP_MOV_I);
      emit(x);
      emit(op);
      if (op inside {OP_MOV_I, OP_ADD_I, OP_ADDC_I, OP_SUBB_I, OP_ANL_I, OP_ORL_I, OP_XRL_I})
         emit(y);
      emit_print();
      r = ref_alu(op, x, y, model_c);
      model_c = r[8];
      expect_byte(r[7:0]);
   endtask

   // ADD then JC or JNC over MOV A,#55h
   task automatic add_jump_block(input logic [7:0] jop, input logic overflow);
      logic [7:0] x;
      logic [7:0] y;
      logic [8:0] r;
      logic       taken;
      x = overflow ? (next_byte() | 8'h80) : (next_byte() & 8'h7F);
      y = overflow ? (next_byte() | 8'h80) : (next_byte() & 8'h7F);
      emit(OP_MOV_I);
      emit(x);
      emit(OP_ADD_I);
      emit(y);
      emit(jop);
      emit(8'h02);
      emit(OP_MOV_I);
      emit(8'h55);
      emit_print();
      r = ref_alu(OP_ADD_I, x, y, model_c);
      model_c = r[8];
      taken = (jop == OP_JC) ? r[8] : !r[8];
      expect_byte(taken ? r[7:0] : 8'h55);
   endtask

   task automatic start_program();
      int i;
      for (i = 0; i < LOAD_BYTES; i++) prog[i] = 8'h00;
      pos = 0;
      model_c = 1'b0;
   endtask

   task automatic build_branch_program();
      int tgt;
      start_program();
      emit(OP_MOV_I);
      emit(next_byte() | 8'h01);   // loop count, never zero
      emit(OP_DEC_A);
      emit(OP_JNZ);
      emit(8'hFD);
      emit_print();
      expect_byte(8'h00);
      add_jump_block(OP_JC, 1'b1);
      add_jump_block(OP_JC, 1'b0);
      add_jump_block(OP_JNC, 1'b1);
      add_jump_block(OP_JNC, 1'b0);
      tgt = pos + 3 + 16;          // past the poisoned block
      emit(OP_LJMP);
      emit(8'h00);
      emit(tgt[7:0]);
      emit(OP_MOV_I);
      emit(8'hEE);
      emit_print();
      add_print_block(OP_MOV_I);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // uart driver and monitors

   task automatic drive_bit(input logic v);
      @(posedge i_clk);
      #1 i_uart_rx = v;
      repeat (BAUD_DIV) @(posedge i_clk);
   endtask

   task automatic send_byte(input logic [7:0] b);
      int i;
      drive_bit(1'b0);
      for (i = 0; i < 8; i++) drive_bit(b[i]);   // lsb first
      drive_bit(1'b1);
   endtask

   always @(negedge i_clk) begin
      if (loading && load_idx < LOAD_BYTES && o_uart_tx !== 1'b1 && !line_err) begin
         $display("o_uart_tx left the idle level while the program was loading");
         errors++;
         line_err = 1'b1;
      end
      if (o_code_wr && (!loading || load_idx >= LOAD_BYTES)) begin
         $display("code write strobe at %0t ns outside the load window", $time);
         errors++;
      end else if (o_code_wr) begin
         check_byte("o_code_addr", o_code_addr, load_idx[7:0]);
         check_byte("o_code_data", o_code_data, prog[load_idx]);
         load_idx++;
      end
   end

   initial begin : uart_monitor
      logic [7:0] b;
      int         i;
      forever begin
         @(negedge i_clk);
         if (i_nrst === 1'b1 && o_uart_tx === 1'b0) begin
            repeat ((BAUD_DIV + 1) / 2) @(negedge i_clk);
            check_byte("o_uart_tx start bit", {7'd0, o_uart_tx}, 8'd0);
            for (i = 0; i < 8; i++) begin
               repeat (BAUD_DIV + 1) @(negedge i_clk);
               b = {b[6:0], o_uart_tx};   // msb first
            end
            repeat (BAUD_DIV + 1) @(negedge i_clk);
            check_byte("o_uart_tx stop bit", {7'd0, o_uart_tx}, 8'd1);
            rx_q.push_back(b);
         end
      end
   end

   initial begin : compare_proc
      logic [7:0] got;
      forever begin
         @(posedge i_clk);
         while (rx_q.size() != 0) begin
            got = rx_q.pop_front();
            if (exp_q.size() == 0) begin
               $display("unexpected extra byte %02h printed at %0t ns", got, $time);
               errors++;
            end else begin
               check_byte("o_uart_tx byte", got, exp_q.pop_front());
               n_cmp++;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence

   task automatic run_test(input string name);
      int err0;
      int cmp0;
      int i;
      err0 = errors;
      cmp0 = n_cmp;
      @(posedge i_clk);
      #1 i_nrst = 1'b0;
      repeat (16) @(posedge i_clk);
      #1 i_nrst = 1'b1;
      @(negedge i_clk);
      check_byte("o_uart_tx", {7'd0, o_uart_tx}, 8'd1);
      check_byte("o_code_wr", {7'd0, o_code_wr}, 8'd0);
      load_idx = 0;
      line_err = 1'b0;
      loading  = 1'b1;
      for (i = 0; i < LOAD_BYTES; i++) send_byte(prog[i]);
      loading = 1'b0;
      if (load_idx != LOAD_BYTES) begin
         $display("%s: loader wrote %0d of %0d bytes", name, load_idx, LOAD_BYTES);
         errors++;
      end
      while (n_cmp < n_exp) @(posedge i_clk);
      repeat (2 * FRAME_CLKS) @(posedge i_clk);   // room for stray frames
      $display("test %s: %0d bytes loaded, %0d bytes printed, %0d errors",
               name, load_idx, n_cmp - cmp0, errors - err0);
   endtask

   initial begin
      int i;
      i_nrst      = 1'b0;
      i_uart_rx   = 1'b1;
      i_code_data = 8'h00;
      start_program();
      for (i = 0; i < 7; i++) add_print_block(ALU_OPS[i]);
      emit(OP_SJMP);
      emit(8'hFE);
      run_test("immediate alu");
      start_program();
      for (i = 0; i < 10; i++) add_print_block(ONE_OPS[i]);
      emit(OP_SJMP);
      emit(8'hFE);
      run_test("single byte ops");
      build_branch_program();
      emit(OP_SJMP);
      emit(8'hFE);
      run_test("branches");
      $display("tests %0d, bytes checked %0d, errors %0d", N_TESTS, n_cmp, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #(LIMIT_NS);
      $display("timeout: the programs did not finish printing in time");
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/ice51_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_top import ice51_pkg::*; (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_uart_rx,
   output logic               o_uart_tx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_addr,
   output logic [7:0]         o_code_data,
   input  wire  [7:0]         i_code_data
);

   logic               loaded;
   logic [CODE_AW-1:0] load_addr;
   logic [CODE_AW-1:0] pc;
   cpu_state_e         state;
   ins_t               ins;
   flags_t             flags;
   logic               tx_start;
   logic [7:0]         tx_byte;
   logic               tx_busy;

   uart_rx_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_code_wr   (o_code_wr),
      .o_load_addr (load_addr),
      .o_code_data (o_code_data),
      .o_loaded    (loaded)
   );

   uart_tx u_tx (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_start (tx_start),
      .i_tx_byte  (tx_byte),
      .o_tx_busy  (tx_busy),
      .o_uart_tx  (o_uart_tx)
   );

   ice51_decode u_decode (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_loaded    (loaded),
      .i_load_addr (load_addr),
      .i_pc        (pc),
      .i_code_data (i_code_data),
      .o_state     (state),
      .o_ins       (ins),
      .o_code_addr (o_code_addr)   // load address first, then pc
   );

   ice51_pc u_pc (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_state (state),
      .i_ins   (ins),
      .i_flags (flags),
      .o_pc    (pc)
   );

   ice51_datapath u_datapath (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_state    (state),
      .i_ins      (ins),
      .i_tx_busy  (tx_busy),
      .o_flags    (flags),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte)
   );

endmodule

`default_nettype wire

/* hdl/ice51_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_datapath import ice51_pkg::*; (
   input  wire             i_clk,
   input  wire             i_nrst,
   input  wire cpu_state_e i_state,
   input  wire ins_t       i_ins,
   input  wire             i_tx_busy,
   output flags_t          o_flags,
   output logic            o_tx_start,
   output logic [7:0]      o_tx_byte
);

   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        carry;
   logic        carry_next;
   logic [7:0]  b;
   logic [15:0] dptr;
   logic        exec;
   logic [7:0]  imm;
   logic        is_b;
   logic [7:0]  add_b;
   logic [8:0]  add_res;
   logic [8:0]  sub_res;

   assign exec = (i_state == ST_EXEC);
   assign imm  = i_ins.h_data;
   assign is_b = (imm == ADDR_B);   // only direct address kept

   ////////////////////////////////////////////////////////////////////////////
   // alu

   // one adder for add, addc and inc a
   assign add_b   = (i_ins.opcode == OP_INC_A) ? 8'd1 : imm;
   assign add_res = {1'b0, acc} + {1'b0, add_b} + {8'd0, (i_ins.opcode == OP_ADDC_I) & carry};
   assign sub_res = {1'b0, acc} - {1'b0, imm} - {8'd0, carry};   // bit 8 is the borrow

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      case (i_ins.opcode)
         OP_MOV_I: acc_next = imm;
         OP_ADD_I, OP_ADDC_I, OP_INC_A: begin
            acc_next   = add_res[7:0];
            carry_next = add_res[8];
         end
         OP_SUBB_I: begin
            acc_next   = sub_res[7:0];
            carry_next = sub_res[8];
         end
         OP_ANL_I:  acc_next = acc & imm;
         OP_ORL_I:  acc_next = acc | imm;
         OP_XRL_I:  acc_next = acc ^ imm;
         OP_DEC_A:  acc_next = acc - 8'd1;   // carry untouched
         OP_CPL_A:  acc_next = ~acc;
         OP_CLR_A:  acc_next = 8'h00;
         OP_RL:     acc_next = {acc[6:0], acc[7]};
         OP_RLC: begin
            acc_next   = {acc[6:0], carry};
            carry_next = acc[7];
         end
         OP_RRC: begin
            acc_next   = {carry, acc[7:1]};
            carry_next = acc[0];
         end
         OP_CLR_C:     carry_next = 1'b0;
         OP_SETB_C:    carry_next = 1'b1;
         OP_MOV_A_DIR: if (is_b) acc_next = b;
         OP_MOVX_RD:   acc_next = (dptr == TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'h00;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers, written only in exec

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         b     <= '0;
         dptr  <= '0;
      end else if (exec) begin
         acc   <= acc_next;
         carry <= carry_next;
         if (i_ins.opcode == OP_MOV_DIR_A && is_b) b <= acc;
         if (i_ins.opcode == OP_MOV_DPTR) dptr <= {i_ins.h_data, i_ins.l_data};
      end
   end

   // jz and jnz look at a itself, there is no psw bit for it
   assign o_flags = '{zero: (acc == 8'h00), carry: carry};

   assign o_tx_start = exec & (i_ins.opcode == OP_MOVX_WR) & (dptr == TX_DATA_ADDR);
   assign o_tx_byte  = acc;

endmodule

`default_nettype wire

/* hdl/ice51_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_pc import ice51_pkg::*; (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire cpu_state_e    i_state,
   input  wire ins_t          i_ins,
   input  wire flags_t        i_flags,
   output logic [CODE_AW-1:0] o_pc
);

   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] rel;
   logic [15:0]        dest;
   logic               decoding;
   logic               exec;
   logic               taken;

   assign decoding = (i_state == ST_DEC0) | (i_state == ST_DEC1) | (i_state == ST_DEC2);
   assign exec     = (i_state == ST_EXEC);
   assign rel      = CODE_AW'(signed'(i_ins.h_data));   // sign extended offset
   assign dest     = {i_ins.h_data, i_ins.l_data};

   always_comb begin
      case (i_ins.opcode)
         OP_SJMP: taken = 1'b1;
         OP_JZ:   taken = i_flags.zero;
         OP_JNZ:  taken = ~i_flags.zero;
         OP_JC:   taken = i_flags.carry;
         OP_JNC:  taken = ~i_flags.carry;
         default: taken = 1'b0;
      endcase
   end

   // by exec the pc sits past the whole instruction
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pc <= '0;
      end else if (decoding) begin
         pc <= pc + 1'b1;                // one byte taken per decode state
      end else if (exec && i_ins.opcode == OP_LJMP) begin
         pc <= dest[CODE_AW-1:0];
      end else if (exec && taken) begin
         pc <= pc + rel;
      end
   end

   // read latency of one clock, so the bus runs a byte ahead while decoding
   assign o_pc = decoding ? pc + 1'b1 : pc;

endmodule

`default_nettype wire

/* hdl/ice51_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_decode import ice51_pkg::*; (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_loaded,
   input  wire  [CODE_AW-1:0] i_load_addr,
   input  wire  [CODE_AW-1:0] i_pc,
   input  wire  [7:0]         i_code_data,
   output cpu_state_e         o_state,
   output ins_t               o_ins,
   output logic [CODE_AW-1:0] o_code_addr
);

   cpu_state_e state;
   logic [7:0] op_q;
   logic [7:0] h_q;
   logic [7:0] l_q;
   logic       two_byte;
   logic       three_byte;

   ////////////////////////////////////////////////////////////////////////////
   // instruction fields, each taken straight off the bus in its own state

   always_comb begin
      o_ins.opcode = (state == ST_DEC0) ? i_code_data : op_q;
      o_ins.h_data = (state == ST_DEC1) ? i_code_data : h_q;
      o_ins.l_data = (state == ST_DEC2) ? i_code_data : l_q;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         op_q <= '0;   // reads as a nop
      end else if (state == ST_DEC0) begin
         op_q <= i_code_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_DEC1) h_q <= i_code_data;
      if (state == ST_DEC2) l_q <= i_code_data;
   end

   // instruction length, anything unknown falls through as one byte
   always_comb begin
      two_byte   = 1'b0;
      three_byte = 1'b0;
      case (o_ins.opcode)
         OP_MOV_I, OP_ADD_I, OP_ADDC_I, OP_SUBB_I,
         OP_ANL_I, OP_ORL_I, OP_XRL_I,
         OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC,
         OP_MOV_A_DIR, OP_MOV_DIR_A: two_byte = 1'b1;
         OP_LJMP, OP_MOV_DPTR:       three_byte = 1'b1;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // control fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ST_FETCH;
      end else begin
         case (state)
            ST_FETCH: if (i_loaded) state <= ST_DEC0;   // wait for the program
            ST_DEC0:  state <= (two_byte | three_byte) ? ST_DEC1 : ST_EXEC;
            ST_DEC1:  state <= three_byte ? ST_DEC2 : ST_EXEC;
            ST_DEC2:  state <= ST_EXEC;
            ST_EXEC:  state <= ST_FETCH;
            default:  state <= ST_FETCH;
         endcase
      end
   end

   assign o_state     = state;
   assign o_code_addr = i_loaded ? i_pc : i_load_addr;

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {ST_FETCH, ST_DEC0, ST_DEC1, ST_DEC2, ST_EXEC});

   // nothing runs until the loader has filled the code memory
   a_idle_while_loading: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_loaded |-> state == ST_FETCH);

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import ice51_pkg::*; (
   input  wire        i_clk,
   input  wire        i_nrst,
   input  wire        i_tx_start,
   input  wire  [7:0] i_tx_byte,
   output logic       o_tx_busy,
   output logic       o_uart_tx
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e         state;
   logic [BIT_CW-1:0] cnt;
   logic [3:0]        bit_no;
   logic [7:0]        shift;
   logic              bit_end;
   logic              frame_end;

   assign bit_end   = (cnt == BIT_CW'(BAUD_DIV));
   assign frame_end = bit_end & (bit_no == 4'd9);   // start, 8 data, then stop ends

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= TX_IDLE;
         cnt    <= '0;
         bit_no <= '0;
      end else begin
         case (state)
            TX_IDLE:  if (i_tx_start) state <= TX_START;
            TX_START: if (bit_end) state <= TX_SEND;
            TX_SEND:  if (frame_end) state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
         if (state == TX_IDLE || bit_end) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
         if (frame_end) begin
            bit_no <= '0;
         end else if (bit_end) begin
            bit_no <= bit_no + 1'b1;
         end
      end
   end

   // msb goes out first, ones shift in behind for the stop bit
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_tx_start) begin
         shift <= i_tx_byte;
      end else if (state == TX_SEND && bit_end) begin
         shift <= {shift[6:0], 1'b1};
      end
   end

   always_comb begin
      case (state)
         TX_IDLE:  o_uart_tx = 1'b1;
         TX_START: o_uart_tx = 1'b0;
         default:  o_uart_tx = shift[7];
      endcase
   end

   assign o_tx_busy = (state != TX_IDLE);

   // software has to poll busy before each write
   a_no_start_while_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_tx_start |-> !o_tx_busy);

endmodule

`default_nettype wire

/* hdl/uart_rx_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_loader import ice51_pkg::*; (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_uart_rx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_load_addr,
   output logic [7:0]         o_code_data,
   output logic               o_loaded
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_WAIT} rx_state_e;

   rx_state_e         state;
   logic [1:0]        rx_sync;
   logic              rx;
   logic [BIT_CW-1:0] cnt;
   logic [7:0]        shift;
   logic              half_bit;
   logic              full_bit;
   logic              rx_done;

   assign rx       = rx_sync[1];
   assign half_bit = (cnt == BIT_CW'(BAUD_DIV / 2));
   assign full_bit = (cnt == BIT_CW'(BAUD_DIV));
   assign rx_done  = (state == RX_WAIT) & full_bit;   // middle of the stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;   // line idles high
      end else begin
         rx_sync <= {rx_sync[0], i_uart_rx};
      end
   end

   // receive fsm, start bit checked at half a bit, data at full bit times
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx && !o_loaded) state <= RX_START;   // closed once the image is in
            end
            RX_START: begin
               if (half_bit) begin
                  cnt   <= '0;
                  state <= rx ? RX_IDLE : RX_DATA;   // false start goes back
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  cnt <= '0;
                  if (shift[0]) state <= RX_WAIT;   // marker reached bit 0
               end
            end
            RX_WAIT: begin
               if (full_bit) state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE && !rx) begin
         shift <= 8'h80;                // marker flags the eighth bit
      end else if (state == RX_DATA && full_bit) begin
         shift <= {rx, shift[7:1]};     // lsb first
      end
   end

   assign o_code_data = shift;
   assign o_code_wr   = rx_done;

   // byte counter doubles as the code write address
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_load_addr <= '0;
         o_loaded    <= 1'b0;
      end else if (o_code_wr) begin
         o_load_addr <= o_load_addr + 1'b1;
         if (o_load_addr == CODE_AW'(LOAD_BYTES - 1)) o_loaded <= 1'b1;
      end
   end

   a_load_closed: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_loaded |-> !o_code_wr);

endmodule

`default_nettype wire

/* hdl/ice51_pkg.sv */
`default_nettype none

package ice51_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // uart timing and memory map

   localparam int BAUD_DIV   = 104;                   // clocks per bit, less one
   localparam int BIT_CW     = $clog2(BAUD_DIV + 1);  // bit-time counter width
   localparam int CODE_AW    = 8;
   localparam int LOAD_BYTES = 2 ** CODE_AW;

   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;   // movx write sends a byte
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;   // movx read gives busy in bit 0
   localparam logic [7:0]  ADDR_B       = 8'hF0;

   ////////////////////////////////////////////////////////////////////////////
   // kept opcodes, standard 8051 encodings

   localparam logic [7:0] OP_LJMP      = 8'h02;
   localparam logic [7:0] OP_INC_A     = 8'h04;
   localparam logic [7:0] OP_RRC       = 8'h13;
   localparam logic [7:0] OP_DEC_A     = 8'h14;
   localparam logic [7:0] OP_RL        = 8'h23;
   localparam logic [7:0] OP_ADD_I     = 8'h24;
   localparam logic [7:0] OP_RLC       = 8'h33;
   localparam logic [7:0] OP_ADDC_I    = 8'h34;
   localparam logic [7:0] OP_JC        = 8'h40;
   localparam logic [7:0] OP_ORL_I     = 8'h44;
   localparam logic [7:0] OP_JNC       = 8'h50;
   localparam logic [7:0] OP_ANL_I     = 8'h54;
   localparam logic [7:0] OP_JZ        = 8'h60;
   localparam logic [7:0] OP_XRL_I     = 8'h64;
   localparam logic [7:0] OP_JNZ       = 8'h70;
   localparam logic [7:0] OP_MOV_I     = 8'h74;
   localparam logic [7:0] OP_SJMP      = 8'h80;
   localparam logic [7:0] OP_MOV_DPTR  = 8'h90;
   localparam logic [7:0] OP_SUBB_I    = 8'h94;
   localparam logic [7:0] OP_CLR_C     = 8'hC3;
   localparam logic [7:0] OP_SETB_C    = 8'hD3;
   localparam logic [7:0] OP_MOVX_RD   = 8'hE0;   // movx a,@dptr
   localparam logic [7:0] OP_CLR_A     = 8'hE4;
   localparam logic [7:0] OP_MOV_A_DIR = 8'hE5;   // only mov a,b is honoured
   localparam logic [7:0] OP_MOVX_WR   = 8'hF0;   // movx @dptr,a
   localparam logic [7:0] OP_CPL_A     = 8'hF4;
   localparam logic [7:0] OP_MOV_DIR_A = 8'hF5;   // only mov b,a is honoured

   ////////////////////////////////////////////////////////////////////////////
   // types

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DEC0,
      ST_DEC1,
      ST_DEC2,
      ST_EXEC
   } cpu_state_e;

   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] h_data;   // first operand byte
      logic [7:0] l_data;   // second operand byte
   } ins_t;

   typedef struct packed {
      logic zero;
      logic carry;
   } flags_t;

endpackage

`default_nettype wire
